//--- hdl/video_config.svh
// geometry of the simulation-sized screen, memory fetch window,
// register number width and register numbers of the video engine
`ifndef VIDEO_CONFIG_SVH
`define VIDEO_CONFIG_SVH

`define VID_VISIBLE_WIDTH       16      // visible pixels per line
`define VID_VISIBLE_HEIGHT      4       // visible lines, at the top of the frame
`define VID_OFFSCREEN_WIDTH     8       // blanking pixels, at the start of each line
`define VID_TOTAL_HEIGHT        7       // lines per frame

`define VID_HSYNC_START         2
`define VID_HSYNC_END           4
`define VID_VSYNC_START         5
`define VID_VSYNC_END           6

// fetch window opens 6 pixels early and closes on the last visible pixel
`define VID_FETCH_BEGIN         (`VID_OFFSCREEN_WIDTH - 6)
`define VID_FETCH_END           (`VID_OFFSCREEN_WIDTH + `VID_VISIBLE_WIDTH - 1)

`define VID_REG_NUM_W           6       // register number width

`define XR_VID_CTRL             6'h00   // border color
`define XR_VID_INTR             6'h03   // write forces a video interrupt
`define XR_SCANLINE             6'h08   // current line, read only
`define XR_VID_HSIZE            6'h0A   // visible width, read only
`define XR_VID_VSIZE            6'h0B   // visible height, read only
`define XR_PA_GFX_CTRL          6'h10
`define XR_PA_DISP_ADDR         6'h12
`define XR_PA_LINE_LEN          6'h13

`define BORDER_RESET_COLOR      8'h08   // dark grey shows the engine is alive

`endif

//--- hdl/video_pkg.sv
// shared data types of the video engine
// word, address, palette index and counter types
// display word union with its 8 and 4 bit pixel views
`default_nettype none

`include "video_config.svh"

package video_pkg;

typedef logic [15:0]    word_t;                 // register and video RAM data word
typedef logic [15:0]    addr_t;                 // video RAM word address
typedef logic [7:0]     color_t;                // palette index

// counters cover the whole line and the whole frame
typedef logic [$clog2(`VID_OFFSCREEN_WIDTH + `VID_VISIBLE_WIDTH)-1:0]  hcount_t;
typedef logic [$clog2(`VID_TOTAL_HEIGHT)-1:0]                         vcount_t;

typedef logic           bpp_t;                  // 0 = 4 bits per pixel, 1 = 8 bits per pixel

// one fetched display word, leftmost pixel in the high bits
typedef union packed {
    word_t              word;
    logic [1:0][7:0]    pix8;                   // two 8 bpp pixels, [1] shown first
    logic [3:0][3:0]    pix4;                   // four 4 bpp pixels, [3] shown first
} disp_word_u;

endpackage

`default_nettype wire

//--- hdl/video_timing.sv
// pixel and line counters with visible flags and line/frame strobes
// registered hsync, vsync and data enable
// memory fetch window on visible lines
`default_nettype none

`include "video_config.svh"

module video_timing
    import video_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_i,
    output      hcount_t    h_count_o,          // pixel within line
    output      vcount_t    v_count_o,          // line within frame
    output      logic       h_visible_o,
    output      logic       v_visible_o,
    output      logic       end_of_line_o,      // last pixel of any line
    output      logic       end_of_frame_o,     // last pixel of last line
    output      logic       end_of_visible_o,   // last pixel of last visible line
    output      logic       mem_fetch_o,        // display fetch window
    output      logic       hsync_o,
    output      logic       vsync_o,
    output      logic       dv_de_o
);

localparam int H_TOTAL = `VID_OFFSCREEN_WIDTH + `VID_VISIBLE_WIDTH;

logic mem_fetch_next;

// flags decoded straight from the counters
always_comb begin
    h_visible_o         = h_count_o >= hcount_t'(`VID_OFFSCREEN_WIDTH);
    v_visible_o         = v_count_o < vcount_t'(`VID_VISIBLE_HEIGHT);
    end_of_line_o       = h_count_o == hcount_t'(H_TOTAL - 1);
    end_of_frame_o      = end_of_line_o && (v_count_o == vcount_t'(`VID_TOTAL_HEIGHT - 1));
    end_of_visible_o    = end_of_line_o && (v_count_o == vcount_t'(`VID_VISIBLE_HEIGHT - 1));
end

// window is set at the begin count and held until the end count
always_comb begin
    if (mem_fetch_o) begin
        mem_fetch_next = h_count_o != hcount_t'(`VID_FETCH_END);
    end else begin
        mem_fetch_next = h_count_o == hcount_t'(`VID_FETCH_BEGIN);
    end
    mem_fetch_next = mem_fetch_next && v_visible_o;
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        h_count_o   <= '0;
        v_count_o   <= '0;
    end else if (end_of_line_o) begin
        h_count_o   <= '0;
        v_count_o   <= end_of_frame_o ? '0 : v_count_o + 1'b1;
    end else begin
        h_count_o   <= h_count_o + 1'b1;
    end
end

// outputs lag the counters by one clock
always_ff @(posedge clk) begin
    if (reset_i) begin
        hsync_o     <= 1'b0;
        vsync_o     <= 1'b0;
        dv_de_o     <= 1'b0;
        mem_fetch_o <= 1'b0;
    end else begin
        hsync_o     <= (h_count_o >= hcount_t'(`VID_HSYNC_START)) &&
                       (h_count_o < hcount_t'(`VID_HSYNC_END));
        vsync_o     <= (v_count_o >= vcount_t'(`VID_VSYNC_START)) &&
                       (v_count_o < vcount_t'(`VID_VSYNC_END));
        dv_de_o     <= h_visible_o && v_visible_o;
        mem_fetch_o <= mem_fetch_next;
    end
end

endmodule

`default_nettype wire

//--- hdl/video_regs.sv
// configuration registers of the video engine
// single cycle writes, read data one clock after the register number
// video interrupt pulse from end of visible frame or a register write
`default_nettype none

`include "video_config.svh"

module video_regs
    import video_pkg::*;
(
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    input  wire logic                       reg_wr_i,       // write strobe
    input  wire logic [`VID_REG_NUM_W-1:0]  reg_num_i,
    input  wire word_t                      reg_data_i,
    output      word_t                      reg_data_o,     // read data, one clock late
    input  wire vcount_t                    v_count_i,
    input  wire logic                       end_of_visible_i,
    output      logic                       video_intr_o,
    output      color_t                     border_color_o,
    output      logic                       pf_blank_o,
    output      bpp_t                       pf_bpp_o,
    output      color_t                     pf_colorbase_o,
    output      addr_t                      pf_start_addr_o,
    output      word_t                      pf_line_len_o
);

word_t rd_data;

always_ff @(posedge clk) begin
    if (reset_i) begin
        border_color_o  <= `BORDER_RESET_COLOR;
        pf_blank_o      <= 1'b1;                // playfield starts blanked
        pf_bpp_o        <= 1'b1;                // 8 bpp
        pf_colorbase_o  <= 8'h00;
        pf_start_addr_o <= 16'h0000;
        pf_line_len_o   <= word_t'(`VID_VISIBLE_WIDTH / 2);   // one line of 8 bpp words
    end else if (reg_wr_i) begin
        case (reg_num_i)
            `XR_VID_CTRL: begin
                border_color_o  <= reg_data_i[7:0];
            end
            `XR_PA_GFX_CTRL: begin
                pf_colorbase_o  <= reg_data_i[15:8];
                pf_blank_o      <= reg_data_i[7];
                pf_bpp_o        <= reg_data_i[4];
            end
            `XR_PA_DISP_ADDR: begin
                pf_start_addr_o <= reg_data_i;
            end
            `XR_PA_LINE_LEN: begin
                pf_line_len_o   <= reg_data_i;
            end
            default: begin
            end
        endcase
    end
end

// one clock pulse, also forced by any write to the interrupt register
always_ff @(posedge clk) begin
    if (reset_i) begin
        video_intr_o    <= 1'b0;
    end else begin
        video_intr_o    <= end_of_visible_i || (reg_wr_i && (reg_num_i == `XR_VID_INTR));
    end
end

// read mux, unused bits and unknown registers give zero
always_comb begin
    case (reg_num_i)
        `XR_VID_CTRL:       rd_data = {8'h00, border_color_o};
        `XR_SCANLINE:       rd_data = word_t'(v_count_i);
        `XR_VID_HSIZE:      rd_data = word_t'(`VID_VISIBLE_WIDTH);
        `XR_VID_VSIZE:      rd_data = word_t'(`VID_VISIBLE_HEIGHT);
        `XR_PA_GFX_CTRL:    rd_data = {pf_colorbase_o, pf_blank_o, 2'b00, pf_bpp_o, 4'h0};
        `XR_PA_DISP_ADDR:   rd_data = pf_start_addr_o;
        `XR_PA_LINE_LEN:    rd_data = pf_line_len_o;
        default:            rd_data = 16'h0000;
    endcase
end

always_ff @(posedge clk) begin
    reg_data_o  <= rd_data;
end

endmodule

`default_nettype wire

//--- hdl/bitmap_playfield.sv
// bitmap playfield with per-frame configuration latch
// line address stepping and sequential video RAM word fetch
// pixel shift-out into palette indices with color base XOR
`default_nettype none

`include "video_config.svh"

module bitmap_playfield
    import video_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic       h_visible_i,
    input  wire logic       v_visible_i,
    input  wire logic       end_of_line_i,
    input  wire logic       end_of_frame_i,
    input  wire logic       mem_fetch_i,        // fetch window from timing
    input  wire color_t     border_color_i,
    input  wire logic       pf_blank_i,
    input  wire bpp_t       pf_bpp_i,
    input  wire color_t     pf_colorbase_i,
    input  wire addr_t      pf_start_addr_i,
    input  wire word_t      pf_line_len_i,
    output      logic       vram_sel_o,
    output      addr_t      vram_addr_o,
    input  wire word_t      vram_data_i,        // valid one clock after vram_sel_o
    output      color_t     color_index_o
);

// first fetch decision leaves room for select, data and shift load
// ahead of the first visible pixel
localparam int FETCH_SKIP = `VID_OFFSCREEN_WIDTH - `VID_FETCH_BEGIN - 4;
localparam int FETCH_SPAN = `VID_VISIBLE_WIDTH;

logic       blank_q;                            // frame copies of the config
bpp_t       bpp_q;
color_t     colorbase_q;
word_t      line_len_q;
addr_t      line_addr;                          // first word of current line
addr_t      fetch_addr;                         // next word to fetch
hcount_t    fetch_pos;                          // clocks since window opened
hcount_t    fetch_off;
logic       fetch_go;
logic       data_valid;                         // vram_data_i holds a fetched word
disp_word_u pix_word;                           // word being shifted out
color_t     pixel;

always_comb begin
    fetch_off   = fetch_pos - hcount_t'(FETCH_SKIP);
    fetch_go    = mem_fetch_i && !blank_q &&
                  (fetch_pos >= FETCH_SKIP) && (fetch_pos < FETCH_SKIP + FETCH_SPAN) &&
                  (bpp_q ? !fetch_off[0] : (fetch_off[1:0] == 2'b00));
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        blank_q     <= 1'b1;
        bpp_q       <= 1'b1;
    end else if (end_of_frame_i) begin
        blank_q     <= pf_blank_i;
        bpp_q       <= pf_bpp_i;
    end
end

always_ff @(posedge clk) begin
    if (end_of_frame_i) begin
        colorbase_q <= pf_colorbase_i;
        line_len_q  <= pf_line_len_i;
        line_addr   <= pf_start_addr_i;
    end else if (end_of_line_i && v_visible_i) begin
        line_addr   <= line_addr + line_len_q;  // step after each visible line
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        fetch_pos   <= '0;
        vram_sel_o  <= 1'b0;
        data_valid  <= 1'b0;
    end else begin
        fetch_pos   <= mem_fetch_i ? fetch_pos + 1'b1 : '0;
        vram_sel_o  <= fetch_go;
        data_valid  <= vram_sel_o;
    end
end

always_ff @(posedge clk) begin
    if (!mem_fetch_i) begin
        fetch_addr  <= line_addr;               // rewind between windows
    end else if (fetch_go) begin
        fetch_addr  <= fetch_addr + 1'b1;
        vram_addr_o <= fetch_addr;
    end
end

// load lands one clock before the word's first pixel
always_ff @(posedge clk) begin
    if (data_valid) begin
        pix_word.word   <= vram_data_i;
    end else if (bpp_q) begin
        pix_word.pix8   <= {pix_word.pix8[0], 8'h00};
    end else begin
        pix_word.pix4   <= {pix_word.pix4[2:0], 4'h0};
    end
end

always_comb begin
    if (bpp_q) begin
        pixel   = pix_word.pix8[1];
    end else begin
        pixel   = {4'h0, pix_word.pix4[3]};     // zero extended nibble
    end
end

// registered to line up with the data enable
always_ff @(posedge clk) begin
    if (!(h_visible_i && v_visible_i) || blank_q) begin
        color_index_o   <= border_color_i;
    end else begin
        color_index_o   <= pixel ^ colorbase_q;
    end
end

endmodule

`default_nettype wire

//--- hdl/video_gen.sv
// top level of the bitmap display engine
// connects video timing, configuration registers and the playfield
`default_nettype none

`include "video_config.svh"

module video_gen
    import video_pkg::*;
(
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    input  wire logic                       reg_wr_i,
    input  wire logic [`VID_REG_NUM_W-1:0]  reg_num_i,
    input  wire word_t                      reg_data_i,
    output      word_t                      reg_data_o,
    output      logic                       video_intr_o,
    output      logic                       vram_sel_o,
    output      addr_t                      vram_addr_o,
    input  wire word_t                      vram_data_i,
    output      color_t                     color_index_o,
    output      logic                       hsync_o,
    output      logic                       vsync_o,
    output      logic                       dv_de_o
);

vcount_t    v_count;
logic       h_visible;
logic       v_visible;
logic       end_of_line;
logic       end_of_frame;
logic       end_of_visible;
logic       mem_fetch;

color_t     border_color;
logic       pf_blank;
bpp_t       pf_bpp;
color_t     pf_colorbase;
addr_t      pf_start_addr;
word_t      pf_line_len;

video_timing u_timing (
    .clk                (clk),
    .reset_i            (reset_i),
    .h_count_o          (),                     // pixel position only matters inside timing
    .v_count_o          (v_count),
    .h_visible_o        (h_visible),
    .v_visible_o        (v_visible),
    .end_of_line_o      (end_of_line),
    .end_of_frame_o     (end_of_frame),
    .end_of_visible_o   (end_of_visible),
    .mem_fetch_o        (mem_fetch),
    .hsync_o            (hsync_o),
    .vsync_o            (vsync_o),
    .dv_de_o            (dv_de_o)
);

video_regs u_regs (
    .clk                (clk),
    .reset_i            (reset_i),
    .reg_wr_i           (reg_wr_i),
    .reg_num_i          (reg_num_i),
    .reg_data_i         (reg_data_i),
    .reg_data_o         (reg_data_o),
    .v_count_i          (v_count),
    .end_of_visible_i   (end_of_visible),
    .video_intr_o       (video_intr_o),
    .border_color_o     (border_color),
    .pf_blank_o         (pf_blank),
    .pf_bpp_o           (pf_bpp),
    .pf_colorbase_o     (pf_colorbase),
    .pf_start_addr_o    (pf_start_addr),
    .pf_line_len_o      (pf_line_len)
);

bitmap_playfield u_playfield (
    .clk                (clk),
    .reset_i            (reset_i),
    .h_visible_i        (h_visible),
    .v_visible_i        (v_visible),
    .end_of_line_i      (end_of_line),
    .end_of_frame_i     (end_of_frame),
    .mem_fetch_i        (mem_fetch),
    .border_color_i     (border_color),
    .pf_blank_i         (pf_blank),
    .pf_bpp_i           (pf_bpp),
    .pf_colorbase_i     (pf_colorbase),
    .pf_start_addr_i    (pf_start_addr),
    .pf_line_len_i      (pf_line_len),
    .vram_sel_o         (vram_sel_o),
    .vram_addr_o        (vram_addr_o),
    .vram_data_i        (vram_data_i),
    .color_index_o      (color_index_o)
);

endmodule

`default_nettype wire

//--- testbench/clock_gen.sv
// clock and reset source of the testbench
// 8 ns clock, reset high for the first 16 rising edges
`default_nettype none

module clock_gen #(
    parameter real  PERIOD_NS    = 8.0,
    parameter int   RESET_CYCLES = 16
) (
    output logic    clk_o,
    output logic    reset_o
);

timeunit 1ns;
timeprecision 1ps;

initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
end

initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    reset_o <= 1'b0;                            // released on a rising edge like all inputs
end

endmodule

`default_nettype wire

//--- testbench/video_checker.sv
// output checker of the video engine
// register read compare, per-pixel frame prediction, interrupt and sync counting
`default_nettype none

`include "video_config.svh"

module video_checker
    import video_pkg::*;
#(
    parameter word_t VRAM_XOR = 16'h5A3C        // video RAM model pattern
) (
    input  wire logic   clk,
    input  wire logic   reset_i,
    input  wire word_t  reg_data_i,
    input  wire logic   video_intr_i,
    input  wire logic   vram_sel_i,
    input  wire color_t color_index_i,
    input  wire logic   hsync_i,
    input  wire logic   vsync_i,
    input  wire logic   dv_de_i
);

timeunit 1ns;
timeprecision 1ps;

localparam int FRAME_TIMEOUT = 400;             // a frame is 168 clocks
localparam int PIXELS = `VID_VISIBLE_WIDTH * `VID_VISIBLE_HEIGHT;
localparam int H_TOTAL = `VID_OFFSCREEN_WIDTH + `VID_VISIBLE_WIDTH;

int checks = 0;
int errors = 0;
int timeouts = 0;
int hsync_cycles = 0;                           // sync high cycles since time zero
int vsync_cycles = 0;

always @(posedge clk) begin
    if (hsync_i) hsync_cycles <= hsync_cycles + 1;
    if (vsync_i) vsync_cycles <= vsync_cycles + 1;
end

task automatic compare(input string name, input int expected, input int actual);
    checks++;
    if (expected != actual) begin
        errors++;
        $display("[ERROR] %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
    end
endtask

task automatic report_failure(input string msg);
    errors++;
    $display("%s", msg);
endtask

task automatic wait_reset_release();
    int n;
    n = 0;
    while (reset_i && n < 100) begin
        @(posedge clk);
        n++;
    end
    if (reset_i) begin
        timeouts++;
        $display("reset was never released");
    end
endtask

// counts interrupt pulses and video RAM selects on the way
task automatic wait_vsync_rise(input string name, inout int intr_seen, inout int sel_seen);
    logic prev;
    logic found;
    int n;
    prev = 1'b1;
    found = 1'b0;
    n = 0;
    while (!found && n < FRAME_TIMEOUT) begin
        @(posedge clk);
        n++;
        if (video_intr_i) intr_seen++;
        if (vram_sel_i) sel_seen++;
        found = vsync_i && !prev;
        prev = vsync_i;
    end
    if (!found) begin
        timeouts++;
        $display("no rising vsync seen while running %s", name);
    end
endtask

// pixel idx of the frame, counted left to right and top to bottom
function automatic color_t expected_pixel(input logic blank, input logic bpp, input color_t cb,
        input color_t border, input addr_t start, input word_t len, input int idx);
    int x;
    int y;
    addr_t a;
    word_t w;
    color_t p;
    x = idx % `VID_VISIBLE_WIDTH;
    y = idx / `VID_VISIBLE_WIDTH;
    if (blank) return border;
    if (bpp) begin
        a = addr_t'(int'(start) + y * int'(len) + x / 2);
        w = a ^ VRAM_XOR;
        p = (x % 2 == 0) ? w[15:8] : w[7:0];    // high byte shown first
    end else begin
        a = addr_t'(int'(start) + y * int'(len) + x / 4);
        w = a ^ VRAM_XOR;
        p = color_t'((w >> (12 - 4 * (x % 4))) & 16'h000F);
    end
    return p ^ cb;
endfunction

task automatic check_read(input string name, input word_t expected);
    @(posedge clk);                             // read data registers here
    @(posedge clk);
    compare(name, expected, reg_data_i);
endtask

task automatic check_frame(input string name, input color_t border, input logic blank,
        input logic bpp, input color_t cb, input addr_t start, input word_t len);
    int intr_seen;
    int sel_seen;
    int idx;
    int n;
    int hsync_start;
    int vsync_start;
    intr_seen = 0;
    sel_seen = 0;
    wait_vsync_rise(name, intr_seen, sel_seen); // config latches before the next frame
    intr_seen = 0;
    sel_seen = 0;
    hsync_start = hsync_cycles;
    vsync_start = vsync_cycles;
    idx = 0;
    n = 0;
    while (idx < PIXELS && n < FRAME_TIMEOUT) begin
        @(posedge clk);
        n++;
        if (video_intr_i) intr_seen++;
        if (vram_sel_i) sel_seen++;
        if (dv_de_i) begin
            compare($sformatf("%s pixel %0d", name, idx),
                    expected_pixel(blank, bpp, cb, border, start, len, idx), color_index_i);
            idx++;
        end
    end
    if (idx < PIXELS) begin
        timeouts++;
        $display("frame %s showed only %0d visible pixels", name, idx);
    end
    wait_vsync_rise(name, intr_seen, sel_seen);
    compare($sformatf("%s interrupts", name), 1, intr_seen);
    // one whole frame lies between the two vsync rises
    compare($sformatf("%s hsync cycles", name),
            (`VID_HSYNC_END - `VID_HSYNC_START) * `VID_TOTAL_HEIGHT,
            hsync_cycles - hsync_start);
    compare($sformatf("%s vsync cycles", name),
            (`VID_VSYNC_END - `VID_VSYNC_START) * H_TOTAL,
            vsync_cycles - vsync_start);
    if (blank && sel_seen != 0) begin
        report_failure($sformatf("video RAM was read during blanked frame %s", name));
    end
endtask

task automatic check_forced_intr(input string name);
    @(posedge clk);
    compare({name, " pulse"}, 1, video_intr_i);
    @(posedge clk);
    compare({name, " end"}, 0, video_intr_i);
endtask

endmodule

`default_nettype wire

//--- testbench/video_gen_tb.sv
// testbench top of the video engine
// runs the stimulus file commands, drives register accesses, models the video RAM
`default_nettype none

`include "video_config.svh"

module video_gen_tb
    import video_pkg::*;
();

timeunit 1ns;
timeprecision 1ps;

localparam word_t VRAM_XOR = 16'h5A3C;
localparam int RUN_LIMIT = 20000;

logic                       clk;
logic                       reset;
logic                       reg_wr;
logic [`VID_REG_NUM_W-1:0]  reg_num;
word_t                      reg_data;
word_t                      reg_rdata;
logic                       video_intr;
logic                       vram_sel;
addr_t                      vram_addr;
word_t                      vram_data;
color_t                     color_index;
logic                       hsync;
logic                       vsync;
logic                       dv_de;

// configuration written so far, starting from the reset values
color_t border_cfg = `BORDER_RESET_COLOR;
logic   blank_cfg = 1'b1;
bpp_t   bpp_cfg = 1'b1;
color_t cb_cfg = 8'h00;
addr_t  start_cfg = 16'h0000;
word_t  len_cfg = 16'h0008;

clock_gen u_clock (
    .clk_o          (clk),
    .reset_o        (reset)
);

video_gen dut_i (
    .clk            (clk),
    .reset_i        (reset),
    .reg_wr_i       (reg_wr),
    .reg_num_i      (reg_num),
    .reg_data_i     (reg_data),
    .reg_data_o     (reg_rdata),
    .video_intr_o   (video_intr),
    .vram_sel_o     (vram_sel),
    .vram_addr_o    (vram_addr),
    .vram_data_i    (vram_data),
    .color_index_o  (color_index),
    .hsync_o        (hsync),
    .vsync_o        (vsync),
    .dv_de_o        (dv_de)
);

video_checker #(.VRAM_XOR(VRAM_XOR)) u_checker (
    .clk            (clk),
    .reset_i        (reset),
    .reg_data_i     (reg_rdata),
    .video_intr_i   (video_intr),
    .vram_sel_i     (vram_sel),
    .color_index_i  (color_index),
    .hsync_i        (hsync),
    .vsync_i        (vsync),
    .dv_de_i        (dv_de)
);

always @(posedge clk) begin
    if (vram_sel) vram_data <= vram_addr ^ VRAM_XOR;  // word ready one clock after select
end

task automatic write_reg(input logic [`VID_REG_NUM_W-1:0] num, input word_t data);
    @(posedge clk);
    reg_wr <= 1'b1;
    reg_num <= num;
    reg_data <= data;
    @(posedge clk);
    reg_wr <= 1'b0;
endtask

task automatic track_config(input logic [`VID_REG_NUM_W-1:0] num, input word_t data);
    case (num)
        `XR_VID_CTRL: border_cfg = data[7:0];
        `XR_PA_GFX_CTRL: begin
            cb_cfg = data[15:8];
            blank_cfg = data[7];
            bpp_cfg = data[4];
        end
        `XR_PA_DISP_ADDR: start_cfg = data;
        `XR_PA_LINE_LEN: len_cfg = data;
        default: begin
        end
    endcase
endtask

task automatic read_reg(input string name, input logic [`VID_REG_NUM_W-1:0] num,
        input word_t expected);
    @(posedge clk);
    reg_num <= num;
    u_checker.check_read(name, expected);
endtask

task automatic run_command(input string cmd, input string name, input word_t num,
        input word_t value);
    if (cmd == "W") begin
        write_reg(num[`VID_REG_NUM_W-1:0], value);
        track_config(num[`VID_REG_NUM_W-1:0], value);
    end else if (cmd == "R") begin
        read_reg(name, num[`VID_REG_NUM_W-1:0], value);
    end else if (cmd == "F") begin
        u_checker.check_frame(name, border_cfg, blank_cfg, bpp_cfg, cb_cfg,
                              start_cfg, len_cfg);
    end else if (cmd == "I") begin
        write_reg(`XR_VID_INTR, value);
        u_checker.check_forced_intr(name);
    end else begin
        u_checker.report_failure($sformatf("unknown stimulus command %s", cmd));
    end
endtask

initial begin
    int fd;
    int fields;
    string line;
    string cmd;
    string name;
    word_t num;
    word_t value;
    reg_wr = 1'b0;
    reg_num = '0;
    reg_data = '0;
    vram_data = '0;
    void'($urandom(32'h9fea2f37));
    u_checker.wait_reset_release();
    fd = $fopen("testbench/video_stimulus.txt", "r");
    if (fd == 0) begin
        u_checker.report_failure("stimulus file testbench/video_stimulus.txt could not be opened");
    end else begin
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            fields = $sscanf(line, "%s %s %h %h", cmd, name, num, value);
            if (fields == 4 && cmd != "#") begin
                repeat ($urandom_range(3, 0)) @(posedge clk);   // idle gap
                run_command(cmd, name, num, value);
            end
        end
        $fclose(fd);
    end
    repeat (4) @(posedge clk);
    $display("checks %0d, errors %0d, timeouts %0d",
             u_checker.checks, u_checker.errors, u_checker.timeouts);
    if (u_checker.errors + u_checker.timeouts == 0) begin
        $display("Verification passed");
    end else begin
        $display("Verification failed");
    end
    $finish;
end

initial begin
    repeat (RUN_LIMIT) @(posedge clk);
    $display("simulation ran past %0d clocks without finishing", RUN_LIMIT);
    $display("Verification failed");
    $finish;
end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+hdl
hdl/video_pkg.sv
hdl/video_timing.sv
hdl/video_regs.sv
hdl/bitmap_playfield.sv
hdl/video_gen.sv
testbench/clock_gen.sv
testbench/video_checker.sv
testbench/video_gen_tb.sv

//--- Bender.yml
package:
  name: video_gen

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/video_pkg.sv
      - hdl/video_timing.sv
      - hdl/video_regs.sv
      - hdl/bitmap_playfield.sv
      - hdl/video_gen.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - testbench/clock_gen.sv
      - testbench/video_checker.sv
      - testbench/video_gen_tb.sv

//--- testbench/video_stimulus.txt
# columns: command, test name, register number (hex), data (hex)
# W writes, R reads and expects data, F checks one frame, I forces the video interrupt
R rst_vid_ctrl 00 0008
R rst_gfx_ctrl 10 0090
R rst_line_len 13 0008
R rst_hsize 0A 0010
R rst_vsize 0B 0004
R rst_unknown 3F 0000
W set_border 00 AB55
R rb_vid_ctrl 00 0055
W set_gfx 10 C3FF
R rb_gfx_ctrl 10 C390
W set_addr 12 1234
R rb_disp_addr 12 1234
W set_len 13 0021
R rb_line_len 13 0021
F blank_frame 00 0000
W gfx_8bpp 10 2510
R rb_gfx_8bpp 10 2510
W len_8bpp 13 000A
F bitmap_8bpp 00 0000
W gfx_4bpp 10 7A00
W addr_4bpp 12 0100
W len_4bpp 13 0005
F bitmap_4bpp 00 0000
I forced_intr 03 0000
